//--- flist.f
+incdir+verification
verilog/fir_dsp_pkg.sv
verilog/dsp_preadder.sv
verilog/dsp_coeff_reg.sv
verilog/dsp_mult_alu.sv
verilog/fir_dsp_core.sv
verification/fir_dsp_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIR tap testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module fir_dsp_core_tb \
    -o fir_dsp_sim

./obj_dir/fir_dsp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished without failure"

//--- verification/fir_dsp_tests.svh
`ifndef FIR_DSP_TESTS_SVH
`define FIR_DSP_TESTS_SVH

//////////////////////////////////////////////////////////////////////
// Reporting and reference helpers
//////////////////////////////////////////////////////////////////////

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_value(input string name, input longint actual, input longint expected);
    assert (actual == expected) else begin
        fail_run($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                           $time, name, actual, expected));
    end
endtask

// p_o and pcout_o of both DUTs
task automatic check_outputs(input longint exp0, input longint exp1);
    check_value("dut0 p_o", longint'(dut0_p), exp0);
    check_value("dut0 pcout_o", longint'(dut0_pcout), exp0);
    check_value("dut1 p_o", longint'(dut1_p), exp1);
    check_value("dut1 pcout_o", longint'(dut1_pcout), exp1);
endtask

// Output rule of one tap wrapped to the accumulator width
function automatic logic signed [P_W-1:0] tap_result(
    input fir_dsp_pkg::preadd_op_e op,
    input fir_dsp_pkg::c_mode_e    c_mode,
    input bit                      use_pcin,
    input logic signed [A_W-1:0]   a,
    input logic signed [D_W-1:0]   d,
    input logic signed [B_W-1:0]   coeff,
    input logic signed [P_W-1:0]   c,
    input logic signed [P_W-1:0]   pcin
);
    logic signed [63:0] pre;
    logic signed [63:0] sum;
    case (op)
        fir_dsp_pkg::PREADD_D_PLUS_A:  pre = longint'(d) + longint'(a);
        fir_dsp_pkg::PREADD_D_MINUS_A: pre = longint'(d) - longint'(a);
        fir_dsp_pkg::PREADD_A:         pre = longint'(a);
        default:                       pre = -longint'(a);
    endcase
    sum = pre * longint'(coeff);
    if (c_mode == fir_dsp_pkg::C_ADD) begin
        sum = sum + longint'(c);
    end else if (c_mode == fir_dsp_pkg::C_SUB) begin
        sum = sum - longint'(c);
    end
    if (use_pcin) begin
        sum = sum + longint'(pcin);
    end
    return sum[P_W-1:0];
endfunction

task automatic clear_history();
    a_hist.delete();
    d_hist.delete();
    c_hist.delete();
    pcin_hist.delete();
    coeff_hist.delete();
    repeat (HIST_LEN) begin
        a_hist.push_front('0);
        d_hist.push_front('0);
        c_hist.push_front('0);
        pcin_hist.push_front('0);
        coeff_hist.push_front('0);
    end
endtask

task automatic record_sample();
    a_hist.push_front(a_i);
    d_hist.push_front(d_i);
    c_hist.push_front(c_i);
    pcin_hist.push_front(pcin_i);
    coeff_hist.push_front(model_active);
    a_hist.delete(HIST_LEN);
    d_hist.delete(HIST_LEN);
    c_hist.delete(HIST_LEN);
    pcin_hist.delete(HIST_LEN);
    coeff_hist.delete(HIST_LEN);
endtask

// Random word with a bias towards the signed extremes of the width
function automatic logic [63:0] random_word(input int width);
    logic [63:0] word;
    int unsigned pick;
    word = {$urandom, $urandom};
    pick = $urandom_range(0, 7);
    if (pick == 0) begin
        word = (64'd1 << (width - 1)) - 64'd1;
    end else if (pick == 1) begin
        word = 64'd1 << (width - 1);
    end
    return word;
endfunction

//////////////////////////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////////////////////////

task automatic set_idle_inputs();
    a_i      <= '0;
    d_i      <= '0;
    b_i      <= '0;
    c_i      <= '0;
    pcin_i   <= '0;
    load_i   <= 1'b0;
    update_i <= 1'b0;
endtask

task automatic drive_idle();
    @(posedge clk_i);
    set_idle_inputs();
endtask

task automatic load_coefficient(input logic signed [B_W-1:0] value);
    @(posedge clk_i);
    b_i    <= value;
    load_i <= 1'b1;
    @(posedge clk_i);
    load_i <= 1'b0;
endtask

task automatic pulse_update();
    @(posedge clk_i);
    update_i <= 1'b1;
    @(posedge clk_i);
    update_i <= 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic check_reset_state();
    repeat (5) begin
        @(negedge clk_i);
        check_outputs(64'sd0, 64'sd0);
        check_value("dut0 bcout_o", longint'(dut0_bcout), 64'sd0);
        check_value("dut1 bcout_o", longint'(dut1_bcout), 64'sd0);
    end
endtask

task automatic test_staged_coefficient();
    load_coefficient(B_W'(5));
    @(negedge clk_i);
    check_value("dut0 bcout_o", longint'(dut0_bcout), 64'sd5);
    check_value("dut1 bcout_o", longint'(dut1_bcout), 64'sd5);
    @(posedge clk_i);
    a_i <= A_W'(3);
    d_i <= D_W'(4);
    // Active coefficient is still zero
    repeat (6) begin
        @(negedge clk_i);
        check_outputs(64'sd0, 64'sd0);
    end
    pulse_update();
    repeat (2) begin
        @(negedge clk_i);
        check_outputs(64'sd0, 64'sd0);
    end
    // (4 + 3) * 5 and (4 - 3) * 5
    repeat (4) begin
        @(negedge clk_i);
        check_outputs(64'sd35, 64'sd5);
    end
    load_coefficient(B_W'(-3));
    @(negedge clk_i);
    check_value("dut0 bcout_o", longint'(dut0_bcout), -64'sd3);
    check_value("dut1 bcout_o", longint'(dut1_bcout), -64'sd3);
    repeat (5) begin
        @(negedge clk_i);
        check_outputs(64'sd35, 64'sd5);
    end
    drive_idle();
    repeat (6) @(posedge clk_i);
endtask

task automatic test_preadd_latency();
    int k;
    load_coefficient(B_W'(2));
    pulse_update();
    repeat (2) @(posedge clk_i);
    @(posedge clk_i);
    d_i <= D_W'(100);
    a_i <= A_W'(7);
    @(posedge clk_i);
    d_i <= '0;
    a_i <= '0;
    for (k = 1; k <= 6; k++) begin
        @(negedge clk_i);
        if (k == 4) begin
            check_outputs(64'sd214, 64'sd186);
        end else begin
            check_outputs(64'sd0, 64'sd0);
        end
    end
endtask

task automatic test_c_pcin_alignment();
    int k;
    @(posedge clk_i);
    c_i <= P_W'(1000);
    @(posedge clk_i);
    c_i <= '0;
    for (k = 1; k <= 4; k++) begin
        @(negedge clk_i);
        if (k == 2) begin
            check_outputs(64'sd1000, -64'sd1000);
        end else begin
            check_outputs(64'sd0, 64'sd0);
        end
    end
    @(posedge clk_i);
    pcin_i <= P_W'(55);
    @(posedge clk_i);
    pcin_i <= '0;
    // Cascade input reaches only the tap that adds it
    for (k = 1; k <= 4; k++) begin
        @(negedge clk_i);
        if (k == 1) begin
            check_outputs(64'sd55, 64'sd0);
        end else begin
            check_outputs(64'sd0, 64'sd0);
        end
    end
endtask

task automatic test_random_stream();
    logic [63:0] word;
    repeat (250) begin
        @(posedge clk_i);
        word = random_word(A_W);
        a_i <= word[A_W-1:0];
        word = random_word(D_W);
        d_i <= word[D_W-1:0];
        word = random_word(B_W);
        b_i <= word[B_W-1:0];
        word = random_word(P_W);
        c_i <= word[P_W-1:0];
        word = random_word(P_W);
        pcin_i <= word[P_W-1:0];
        // Strobes about one cycle in sixteen
        load_i   <= ($urandom_range(0, 15) == 0);
        update_i <= ($urandom_range(0, 15) == 0);
    end
    drive_idle();
    repeat (6) @(posedge clk_i);
endtask

`endif

//--- verification/fir_dsp_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fir_dsp_core_tb;

    localparam int A_W      = fir_dsp_pkg::A_W;
    localparam int D_W      = fir_dsp_pkg::D_W;
    localparam int B_W      = fir_dsp_pkg::B_W;
    localparam int P_W      = fir_dsp_pkg::P_W;
    localparam int HIST_LEN = 4;
    // The tests take about 350 cycles
    localparam int TIMEOUT_CYCLES = 1000;

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    logic signed [A_W-1:0] a_i;
    logic signed [D_W-1:0] d_i;
    logic signed [B_W-1:0] b_i;
    logic signed [P_W-1:0] c_i;
    logic signed [P_W-1:0] pcin_i;
    logic                  load_i;
    logic                  update_i;

    logic signed [P_W-1:0] dut0_p;
    logic signed [P_W-1:0] dut0_pcout;
    logic signed [B_W-1:0] dut0_bcout;
    logic signed [P_W-1:0] dut1_p;
    logic signed [P_W-1:0] dut1_pcout;
    logic signed [B_W-1:0] dut1_bcout;

    // Reference model history with the newest edge at index 0 of each queue
    logic signed [A_W-1:0] a_hist[$];
    logic signed [D_W-1:0] d_hist[$];
    logic signed [P_W-1:0] c_hist[$];
    logic signed [P_W-1:0] pcin_hist[$];
    logic signed [B_W-1:0] coeff_hist[$];
    logic signed [B_W-1:0] model_stage;
    logic signed [B_W-1:0] model_active;
    logic signed [P_W-1:0] exp0_p;
    logic signed [P_W-1:0] exp1_p;
    int                    cycle_count = 0;

    `include "fir_dsp_tests.svh"

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // DUTs
    //////////////////////////////////////////////////////////////////////

    fir_dsp_core #(
        .PREADD_OP (fir_dsp_pkg::PREADD_D_PLUS_A),
        .C_MODE    (fir_dsp_pkg::C_ADD),
        .ADD_PCIN  (1'b1)
    ) dut0 (
        .clk_i, .rst_n_i, .a_i, .d_i, .b_i, .c_i, .pcin_i, .load_i, .update_i,
        .p_o (dut0_p), .pcout_o (dut0_pcout), .bcout_o (dut0_bcout)
    );

    fir_dsp_core #(
        .PREADD_OP (fir_dsp_pkg::PREADD_D_MINUS_A),
        .C_MODE    (fir_dsp_pkg::C_SUB),
        .ADD_PCIN  (1'b0)
    ) dut1 (
        .clk_i, .rst_n_i, .a_i, .d_i, .b_i, .c_i, .pcin_i, .load_i, .update_i,
        .p_o (dut1_p), .pcout_o (dut1_pcout), .bcout_o (dut1_bcout)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and checker
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : ref_model
        logic signed [B_W-1:0] next_active;
        if (!rst_n_i) begin
            model_stage  = '0;
            model_active = '0;
            clear_history();
        end else begin
            // Update copies the staging value from before this edge
            next_active = update_i ? model_stage : model_active;
            if (load_i) begin
                model_stage = b_i;
            end
            model_active = next_active;
            record_sample();
        end
        // Samples from 3 edges back with the coefficient after edge t-2 and C from t-1
        exp0_p = tap_result(fir_dsp_pkg::PREADD_D_PLUS_A, fir_dsp_pkg::C_ADD, 1'b1,
                            a_hist[3], d_hist[3], coeff_hist[2], c_hist[1], pcin_hist[0]);
        exp1_p = tap_result(fir_dsp_pkg::PREADD_D_MINUS_A, fir_dsp_pkg::C_SUB, 1'b0,
                            a_hist[3], d_hist[3], coeff_hist[2], c_hist[1], pcin_hist[0]);
    end

    always @(negedge clk_i) begin
        check_outputs(longint'(exp0_p), longint'(exp1_p));
        check_value("dut0 bcout_o", longint'(dut0_bcout), longint'(model_stage));
        check_value("dut1 bcout_o", longint'(dut1_bcout), longint'(model_stage));
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h4638));
        rst_n_i <= 1'b0;
        set_idle_inputs();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        check_reset_state();
        test_staged_coefficient();
        test_preadd_latency();
        test_c_pcin_alignment();
        test_random_stream();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dsp_coeff_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_coeff_reg (
    input  wire                                clk_i,
    input  wire                                rst_n_i,
    input  wire signed [fir_dsp_pkg::B_W-1:0]  b_i,
    input  wire                                load_i,
    input  wire                                update_i,
    output logic signed [fir_dsp_pkg::B_W-1:0] coeff_o,
    output logic signed [fir_dsp_pkg::B_W-1:0] bcout_o
);

    localparam int B_W = fir_dsp_pkg::B_W;

    logic signed [B_W-1:0] stage_q;
    logic signed [B_W-1:0] active_q;

    //////////////////////////////////////////////////////////////////////
    // Staging register
    //////////////////////////////////////////////////////////////////////

    // Also feeds the next tap so a chain loads as a shift register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else if (load_i) begin
            stage_q <= b_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Active register
    //////////////////////////////////////////////////////////////////////

    // Holds the coefficient in use while a new one is staged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= '0;
        end else if (update_i) begin
            active_q <= stage_q;
        end
    end

    assign bcout_o = stage_q;
    assign coeff_o = active_q;

endmodule

`default_nettype wire

//--- verilog/dsp_mult_alu.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_mult_alu #(
    parameter fir_dsp_pkg::c_mode_e C_MODE   = fir_dsp_pkg::C_ADD,
    parameter bit                   ADD_PCIN = 1'b1
) (
    input  wire                                     clk_i,
    input  wire                                     rst_n_i,
    input  wire signed [fir_dsp_pkg::PREADD_W-1:0]  preadd_i,
    input  wire signed [fir_dsp_pkg::B_W-1:0]       coeff_i,
    input  wire signed [fir_dsp_pkg::P_W-1:0]       c_i,
    input  wire signed [fir_dsp_pkg::P_W-1:0]       pcin_i,
    output logic signed [fir_dsp_pkg::P_W-1:0]      p_o
);

    localparam int PRODUCT_W = fir_dsp_pkg::PRODUCT_W;
    localparam int P_W       = fir_dsp_pkg::P_W;

    // Multiply stage
    logic signed [PRODUCT_W-1:0] product;
    logic signed [PRODUCT_W-1:0] m_q;
    logic signed [P_W-1:0]       c_q;

    // Post-adder operands
    logic signed [P_W-1:0] m_ext;
    logic signed [P_W-1:0] c_term;
    logic                  c_carry;
    logic signed [P_W-1:0] carry_term;
    logic signed [P_W-1:0] pcin_term;
    logic signed [P_W-1:0] p_d;

    //////////////////////////////////////////////////////////////////////
    // Multiplier and C register
    //////////////////////////////////////////////////////////////////////

    // Both operands widen to the product width before the multiply
    assign product = preadd_i * coeff_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            m_q <= '0;
            c_q <= '0;
        end else begin
            m_q <= product;
            c_q <= c_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Post-adder operand selection
    //////////////////////////////////////////////////////////////////////

    assign m_ext = {{(P_W-PRODUCT_W){m_q[PRODUCT_W-1]}}, m_q};

    // Subtracting C is ~C plus a carry-in of one
    always_comb begin
        case (C_MODE)
            fir_dsp_pkg::C_ADD: begin
                c_term  = c_q;
                c_carry = 1'b0;
            end
            fir_dsp_pkg::C_SUB: begin
                c_term  = ~c_q;
                c_carry = 1'b1;
            end
            default: begin
                c_term  = '0;
                c_carry = 1'b0;
            end
        endcase
    end

    assign carry_term = {{(P_W-1){1'b0}}, c_carry};

    // Cascade input goes straight into the adder with no register
    assign pcin_term = ADD_PCIN ? pcin_i : '0;

    //////////////////////////////////////////////////////////////////////
    // Post-adder and P register
    //////////////////////////////////////////////////////////////////////

    // Wraps at P_W bits like the hardware accumulator
    assign p_d = m_ext + c_term + pcin_term + carry_term;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p_o <= '0;
        end else begin
            p_o <= p_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_preadder.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_preadder #(
    parameter fir_dsp_pkg::preadd_op_e PREADD_OP = fir_dsp_pkg::PREADD_D_PLUS_A
) (
    input  wire                                     clk_i,
    input  wire                                     rst_n_i,
    input  wire signed [fir_dsp_pkg::A_W-1:0]       a_i,
    input  wire signed [fir_dsp_pkg::D_W-1:0]       d_i,
    output logic signed [fir_dsp_pkg::PREADD_W-1:0] preadd_o
);

    localparam int A_W      = fir_dsp_pkg::A_W;
    localparam int D_W      = fir_dsp_pkg::D_W;
    localparam int PREADD_W = fir_dsp_pkg::PREADD_W;

    // D only enters the sum for the two D modes
    localparam bit USE_D = (PREADD_OP == fir_dsp_pkg::PREADD_D_PLUS_A) ||
                           (PREADD_OP == fir_dsp_pkg::PREADD_D_MINUS_A);

    logic signed [A_W-1:0]      a_q;
    logic signed [PREADD_W-1:0] a_ext;
    logic signed [PREADD_W-1:0] d_ext;
    logic signed [PREADD_W-1:0] preadd_d;

    //////////////////////////////////////////////////////////////////////
    // Input registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_q <= '0;
        end else begin
            a_q <= a_i;
        end
    end

    assign a_ext = {{(PREADD_W-A_W){a_q[A_W-1]}}, a_q};

    generate
        if (USE_D) begin : g_dreg
            logic signed [D_W-1:0] d_q;

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    d_q <= '0;
                end else begin
                    d_q <= d_i;
                end
            end

            assign d_ext = {{(PREADD_W-D_W){d_q[D_W-1]}}, d_q};
        end else begin : g_no_dreg
            // Without a D register the operand is a constant zero
            assign d_ext = '0;
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // Pre-adder and its output register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (PREADD_OP)
            fir_dsp_pkg::PREADD_D_PLUS_A:  preadd_d = d_ext + a_ext;
            fir_dsp_pkg::PREADD_D_MINUS_A: preadd_d = d_ext - a_ext;
            fir_dsp_pkg::PREADD_A:         preadd_d = a_ext;
            fir_dsp_pkg::PREADD_NEG_A:     preadd_d = -a_ext;
            default:                       preadd_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            preadd_o <= '0;
        end else begin
            preadd_o <= preadd_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fir_dsp_core.sv
`timescale 1ns/1ps
`default_nettype none

module fir_dsp_core #(
    parameter fir_dsp_pkg::preadd_op_e PREADD_OP = fir_dsp_pkg::PREADD_D_PLUS_A,
    parameter fir_dsp_pkg::c_mode_e    C_MODE    = fir_dsp_pkg::C_ADD,
    parameter bit                      ADD_PCIN  = 1'b1
) (
    input  wire                                 clk_i,
    input  wire                                 rst_n_i,

    // Data samples into the pre-adder
    input  wire signed [fir_dsp_pkg::A_W-1:0]   a_i,
    input  wire signed [fir_dsp_pkg::D_W-1:0]   d_i,

    // Coefficient load port
    input  wire signed [fir_dsp_pkg::B_W-1:0]   b_i,
    input  wire                                 load_i,
    input  wire                                 update_i,

    // Post-adder terms
    input  wire signed [fir_dsp_pkg::P_W-1:0]   c_i,
    input  wire signed [fir_dsp_pkg::P_W-1:0]   pcin_i,

    // Result and cascade outputs
    output logic signed [fir_dsp_pkg::P_W-1:0]  p_o,
    output logic signed [fir_dsp_pkg::P_W-1:0]  pcout_o,
    output logic signed [fir_dsp_pkg::B_W-1:0]  bcout_o
);

    localparam int PREADD_W = fir_dsp_pkg::PREADD_W;
    localparam int B_W      = fir_dsp_pkg::B_W;

    // Between the stages
    logic signed [PREADD_W-1:0] preadd;
    logic signed [B_W-1:0]      coeff;

    //////////////////////////////////////////////////////////////////////
    // Pre-adder
    //////////////////////////////////////////////////////////////////////

    // Two edges from a and d to the pre-add result
    dsp_preadder #(
        .PREADD_OP (PREADD_OP)
    ) u_preadder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .a_i      (a_i),
        .d_i      (d_i),
        .preadd_o (preadd)
    );

    //////////////////////////////////////////////////////////////////////
    // Coefficient
    //////////////////////////////////////////////////////////////////////

    dsp_coeff_reg u_coeff (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .b_i      (b_i),
        .load_i   (load_i),
        .update_i (update_i),
        .coeff_o  (coeff),
        .bcout_o  (bcout_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Multiplier and post-adder
    //////////////////////////////////////////////////////////////////////

    // Two more edges to P so C meets the product of samples two cycles older
    dsp_mult_alu #(
        .C_MODE   (C_MODE),
        .ADD_PCIN (ADD_PCIN)
    ) u_mult_alu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .preadd_i (preadd),
        .coeff_i  (coeff),
        .c_i      (c_i),
        .pcin_i   (pcin_i),
        .p_o      (p_o)
    );

    // Partial sum for the next tap in the chain
    assign pcout_o = p_o;

endmodule

`default_nettype wire

//--- verilog/fir_dsp_pkg.sv
`default_nettype none

package fir_dsp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data path widths
    //////////////////////////////////////////////////////////////////////

    // Sample inputs to the pre-adder
    localparam int A_W = 26;
    localparam int D_W = 26;

    // One guard bit so d+a or d-a cannot overflow
    localparam int PREADD_W = 27;

    // Coefficient port and both coefficient registers
    localparam int B_W = 18;

    // Full signed product of the pre-add result and the coefficient
    localparam int PRODUCT_W = 45;

    // Post-adder, C port, cascade and P output
    localparam int P_W = 48;

    //////////////////////////////////////////////////////////////////////
    // Operation selects
    //////////////////////////////////////////////////////////////////////

    // Pre-adder function
    // The A-only modes leave the D input out of the path
    typedef enum logic [1:0] {
        PREADD_D_PLUS_A  = 2'b00,
        PREADD_D_MINUS_A = 2'b01,
        PREADD_A         = 2'b10,
        PREADD_NEG_A     = 2'b11
    } preadd_op_e;

    // Use of the C term in the post-adder
    typedef enum logic [1:0] {
        C_NONE = 2'b00,
        C_ADD  = 2'b01,
        C_SUB  = 2'b10
    } c_mode_e;

endpackage

`default_nettype wire
